// File: hdl/rnn_pkg.sv
`default_nettype none

package rnn_pkg;

	// --------------------------------------------------
	// cell dimensions
	// --------------------------------------------------
	localparam int DIM      = 3;
	localparam int STEPS    = 3;
	// one word per cycle, row-major over a DIM x DIM matrix
	localparam int LOAD_LEN = DIM * STEPS;

	// --------------------------------------------------
	// arithmetic widths
	// --------------------------------------------------
	// signed fixed point, binary point set by FRAC_BITS
	typedef logic signed [15:0] data_t;
	typedef logic signed [31:0] prod_t;
	// six products plus headroom
	typedef logic signed [35:0] acc_t;

	// row or step number
	typedef logic [1:0] idx_t;

	// control phases
	typedef enum logic [2:0] {
		S_IDLE,
		S_LOAD,
		S_RECUR,
		S_OUTPUT,
		S_DONE
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/rnn_dot_unit.sv
`default_nettype none

module rnn_dot_unit #(
	parameter int FRAC_BITS  = 8,
	parameter int LEAK_SHIFT = 3
) (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               i_row_en,
	input  wire                               i_activate,
	input  wire rnn_pkg::data_t [rnn_pkg::DIM-1:0] i_row_a,
	input  wire rnn_pkg::data_t [rnn_pkg::DIM-1:0] i_row_b,
	input  wire rnn_pkg::data_t [rnn_pkg::DIM-1:0] i_h_vec,
	input  wire rnn_pkg::data_t [rnn_pkg::DIM-1:0] i_x_vec,
	output logic                              o_res_valid,
	output rnn_pkg::data_t                    o_res
);

	localparam int DATA_W = $bits(rnn_pkg::data_t);
	localparam rnn_pkg::acc_t SAT_MAX = (rnn_pkg::acc_t'(1) <<< (DATA_W - 1)) - 1;
	localparam rnn_pkg::acc_t SAT_MIN = -(rnn_pkg::acc_t'(1) <<< (DATA_W - 1));

	rnn_pkg::prod_t [rnn_pkg::DIM-1:0] prod_h;
	rnn_pkg::prod_t [rnn_pkg::DIM-1:0] prod_x;
	rnn_pkg::acc_t                     acc;
	rnn_pkg::acc_t                     scaled;
	rnn_pkg::data_t                    sat;
	rnn_pkg::data_t                    act;

	// --------------------------------------------------
	// six-term multiply-accumulate
	// --------------------------------------------------
	always_comb begin
		acc = '0;
		for (int i = 0; i < rnn_pkg::DIM; i++) begin
			prod_h[i] = $signed(i_row_a[i]) * $signed(i_h_vec[i]);
			prod_x[i] = $signed(i_row_b[i]) * $signed(i_x_vec[i]);
			acc = acc + rnn_pkg::acc_t'($signed(prod_h[i]))
				+ rnn_pkg::acc_t'($signed(prod_x[i]));
		end
	end

	// --------------------------------------------------
	// rescale, saturate, leaky rectifier
	// --------------------------------------------------
	// truncating shift back to FRAC_BITS fraction bits
	assign scaled = acc >>> FRAC_BITS;

	always_comb begin
		if (scaled > SAT_MAX) begin
			sat = rnn_pkg::data_t'(SAT_MAX);
		end else if (scaled < SAT_MIN) begin
			sat = rnn_pkg::data_t'(SAT_MIN);
		end else begin
			sat = rnn_pkg::data_t'(scaled);
		end
	end

	// negative slope of 2^-LEAK_SHIFT
	always_comb begin
		act = sat;
		if (i_activate && sat[DATA_W-1]) begin
			act = sat >>> LEAK_SHIFT;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_res_valid <= 1'b0;
			o_res       <= '0;
		end else begin
			o_res_valid <= i_row_en;
			if (i_row_en) begin
				o_res <= act;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/rnn_step_counter.sv
`default_nettype none

module rnn_step_counter (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire rnn_pkg::ctrl_state_t i_state,
	output rnn_pkg::idx_t        o_row,
	output rnn_pkg::idx_t        o_step,
	output logic                 o_last_row,
	output logic                 o_last_step
);

	rnn_pkg::idx_t row;
	rnn_pkg::idx_t step;
	rnn_pkg::idx_t row_inc;
	rnn_pkg::idx_t step_inc;

	assign o_last_row  = (row == rnn_pkg::idx_t'(rnn_pkg::DIM - 1));
	assign o_last_step = (step == rnn_pkg::idx_t'(rnn_pkg::STEPS - 1));

	// wrap at the end of each row run and after the last step
	assign row_inc  = o_last_row ? '0 : row + 1'b1;
	assign step_inc = o_last_step ? '0 : step + 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row  <= '0;
			step <= '0;
		end else begin
			case (i_state)
				// load rows and output bursts both close a step
				rnn_pkg::S_LOAD,
				rnn_pkg::S_OUTPUT: begin
					row <= row_inc;
					if (o_last_row) begin
						step <= step_inc;
					end
				end
				rnn_pkg::S_RECUR: row <= row_inc;
				default: begin
					row  <= '0;
					step <= '0;
				end
			endcase
		end
	end

	assign o_row  = row;
	assign o_step = step;

endmodule

`default_nettype wire

// File: hdl/rnn_operand_store.sv
`default_nettype none

module rnn_operand_store (
	input  wire                                    clk,
	input  wire                                    rst_n,
	input  wire                                    i_load_en,
	input  wire rnn_pkg::idx_t                     i_row,
	input  wire rnn_pkg::idx_t                     i_step,
	input  wire rnn_pkg::data_t                    i_weight_u,
	input  wire rnn_pkg::data_t                    i_weight_w,
	input  wire rnn_pkg::data_t                    i_weight_v,
	input  wire rnn_pkg::data_t                    i_data_x,
	input  wire rnn_pkg::ctrl_state_t              i_state,
	output rnn_pkg::data_t [rnn_pkg::DIM-1:0]      o_mat_row_a,
	output rnn_pkg::data_t [rnn_pkg::DIM-1:0]      o_mat_row_b,
	output rnn_pkg::data_t [rnn_pkg::DIM-1:0]      o_x_vec
);

	// --------------------------------------------------
	// register files, one packed row per entry
	// --------------------------------------------------
	rnn_pkg::data_t [rnn_pkg::DIM-1:0] mat_u [rnn_pkg::DIM];
	rnn_pkg::data_t [rnn_pkg::DIM-1:0] mat_w [rnn_pkg::DIM];
	rnn_pkg::data_t [rnn_pkg::DIM-1:0] mat_v [rnn_pkg::DIM];
	rnn_pkg::data_t [rnn_pkg::DIM-1:0] x_tab [rnn_pkg::STEPS];

	logic out_phase;

	// during load the step count names the matrix row,
	// the row count names the column
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mat_u <= '{default: '0};
			mat_w <= '{default: '0};
			mat_v <= '{default: '0};
			x_tab <= '{default: '0};
		end else if (i_load_en) begin
			mat_u[i_step][i_row] <= i_weight_u;
			mat_w[i_step][i_row] <= i_weight_w;
			mat_v[i_step][i_row] <= i_weight_v;
			x_tab[i_step][i_row] <= i_data_x;
		end
	end

	// --------------------------------------------------
	// row read out
	// --------------------------------------------------
	assign out_phase = (i_state == rnn_pkg::S_OUTPUT);

	always_comb begin
		if (out_phase) begin
			o_mat_row_a = mat_v[i_row];
			// no input term in y
			o_mat_row_b = '0;
		end else begin
			o_mat_row_a = mat_w[i_row];
			o_mat_row_b = mat_u[i_row];
		end
	end

	assign o_x_vec = x_tab[i_step];

endmodule

`default_nettype wire

// File: hdl/rnn_hidden_store.sv
`default_nettype none

module rnn_hidden_store (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               i_load_en,
	input  wire rnn_pkg::idx_t                i_row,
	input  wire rnn_pkg::idx_t                i_step,
	input  wire rnn_pkg::data_t               i_data_h,
	input  wire                               i_res_valid,
	input  wire rnn_pkg::data_t               i_res,
	input  wire                               i_row_en,
	input  wire                               i_commit,
	output rnn_pkg::data_t [rnn_pkg::DIM-1:0] o_h_vec
);

	rnn_pkg::data_t [rnn_pkg::DIM-1:0] h_cur;
	rnn_pkg::data_t [rnn_pkg::DIM-1:0] h_nxt;
	rnn_pkg::data_t [rnn_pkg::DIM-1:0] h_fwd;
	rnn_pkg::idx_t                     row_d;

	// row of the value now sitting in the result register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_d <= '0;
		end else if (i_row_en) begin
			row_d <= i_row;
		end
	end

	// next vector with the pending result merged in
	always_comb begin
		h_fwd = h_nxt;
		if (i_res_valid) begin
			h_fwd[row_d] = i_res;
		end
	end

	// y results also land in next, the following recurrence overwrites them
	always_ff @(posedge clk) begin
		h_nxt <= h_fwd;
		if (i_load_en && i_step == '0) begin
			h_cur[i_row] <= i_data_h;
		end else if (i_commit) begin
			h_cur <= h_fwd;
		end
	end

	// on commit the first V row already sees the new state
	assign o_h_vec = i_commit ? h_fwd : h_cur;

endmodule

`default_nettype wire

// File: hdl/rnn_ctrl_fsm.sv
`default_nettype none

module rnn_ctrl_fsm (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  i_in_valid,
	input  wire                  i_last_row,
	input  wire                  i_last_step,
	input  wire                  i_res_valid,
	output rnn_pkg::ctrl_state_t o_state,
	output logic                 o_load_en,
	output logic                 o_row_en,
	output logic                 o_activate,
	output logic                 o_commit,
	output logic                 o_out_valid
);

	rnn_pkg::ctrl_state_t state;
	rnn_pkg::ctrl_state_t phase;
	rnn_pkg::ctrl_state_t next_state;
	logic                 commit_q;
	logic                 out_phase_q;

	// --------------------------------------------------
	// phase seen by the rest of the design
	// --------------------------------------------------
	// first load word arrives while still idle, so load starts at once
	always_comb begin
		phase = state;
		if (state == rnn_pkg::S_IDLE && i_in_valid) begin
			phase = rnn_pkg::S_LOAD;
		end
	end

	always_comb begin
		next_state = phase;
		case (phase)
			rnn_pkg::S_LOAD: begin
				if (i_last_row && i_last_step) begin
					next_state = rnn_pkg::S_RECUR;
				end
			end
			rnn_pkg::S_RECUR: begin
				if (i_last_row) begin
					next_state = rnn_pkg::S_OUTPUT;
				end
			end
			rnn_pkg::S_OUTPUT: begin
				if (i_last_row) begin
					next_state = i_last_step ? rnn_pkg::S_DONE : rnn_pkg::S_RECUR;
				end
			end
			rnn_pkg::S_DONE: next_state = rnn_pkg::S_IDLE;
			default: next_state = phase;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= rnn_pkg::S_IDLE;
			commit_q    <= 1'b0;
			out_phase_q <= 1'b0;
		end else begin
			state       <= next_state;
			// last hidden row is in the result register one cycle later
			commit_q    <= (phase == rnn_pkg::S_RECUR) && i_last_row;
			out_phase_q <= (phase == rnn_pkg::S_OUTPUT);
		end
	end

	// --------------------------------------------------
	// strobes
	// --------------------------------------------------
	assign o_state     = phase;
	assign o_load_en   = (phase == rnn_pkg::S_LOAD) && i_in_valid;
	assign o_row_en    = (phase == rnn_pkg::S_RECUR) || (phase == rnn_pkg::S_OUTPUT);
	// rectifier on hidden rows only, y stays linear
	assign o_activate  = (phase == rnn_pkg::S_RECUR);
	assign o_commit    = commit_q;
	assign o_out_valid = out_phase_q && i_res_valid;

endmodule

`default_nettype wire

// File: hdl/rnn_top.sv
`default_nettype none

module rnn_top #(
	parameter int FRAC_BITS  = 8,
	parameter int LEAK_SHIFT = 3
) (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 i_in_valid,
	input  wire rnn_pkg::data_t i_weight_u,
	input  wire rnn_pkg::data_t i_weight_w,
	input  wire rnn_pkg::data_t i_weight_v,
	input  wire rnn_pkg::data_t i_data_x,
	input  wire rnn_pkg::data_t i_data_h,
	output logic                o_out_valid,
	output rnn_pkg::data_t      o_out
);

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	rnn_pkg::ctrl_state_t state;
	logic                 load_en;
	logic                 row_en;
	logic                 activate;
	logic                 commit;
	rnn_pkg::idx_t        row;
	rnn_pkg::idx_t        step;
	logic                 last_row;
	logic                 last_step;

	// --------------------------------------------------
	// data path
	// --------------------------------------------------
	rnn_pkg::data_t [rnn_pkg::DIM-1:0] mat_row_a;
	rnn_pkg::data_t [rnn_pkg::DIM-1:0] mat_row_b;
	rnn_pkg::data_t [rnn_pkg::DIM-1:0] x_vec;
	rnn_pkg::data_t [rnn_pkg::DIM-1:0] h_vec;
	logic                              res_valid;
	rnn_pkg::data_t                    res;

	rnn_ctrl_fsm u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_in_valid  (i_in_valid),
		.i_last_row  (last_row),
		.i_last_step (last_step),
		.i_res_valid (res_valid),
		.o_state     (state),
		.o_load_en   (load_en),
		.o_row_en    (row_en),
		.o_activate  (activate),
		.o_commit    (commit),
		.o_out_valid (o_out_valid)
	);

	rnn_step_counter u_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_state     (state),
		.o_row       (row),
		.o_step      (step),
		.o_last_row  (last_row),
		.o_last_step (last_step)
	);

	rnn_operand_store u_operands (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_load_en   (load_en),
		.i_row       (row),
		.i_step      (step),
		.i_weight_u  (i_weight_u),
		.i_weight_w  (i_weight_w),
		.i_weight_v  (i_weight_v),
		.i_data_x    (i_data_x),
		.i_state     (state),
		.o_mat_row_a (mat_row_a),
		.o_mat_row_b (mat_row_b),
		.o_x_vec     (x_vec)
	);

	rnn_hidden_store u_hidden (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_load_en   (load_en),
		.i_row       (row),
		.i_step      (step),
		.i_data_h    (i_data_h),
		.i_res_valid (res_valid),
		.i_res       (res),
		.i_row_en    (row_en),
		.i_commit    (commit),
		.o_h_vec     (h_vec)
	);

	rnn_dot_unit #(
		.FRAC_BITS  (FRAC_BITS),
		.LEAK_SHIFT (LEAK_SHIFT)
	) u_dot (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_row_en    (row_en),
		.i_activate  (activate),
		.i_row_a     (mat_row_a),
		.i_row_b     (mat_row_b),
		.i_h_vec     (h_vec),
		.i_x_vec     (x_vec),
		.o_res_valid (res_valid),
		.o_res       (res)
	);

	// y rows leave straight from the result register
	assign o_out = res;

endmodule

`default_nettype wire

// File: verification/rnn_asserts.sv
`default_nettype none

module rnn_asserts (
	input wire                       clk,
	input wire                       rst_n,
	input wire rnn_pkg::ctrl_state_t i_state_q,
	input wire rnn_pkg::ctrl_state_t i_phase,
	input wire                       i_out_valid
);

	// valid cycles seen in a row so far
	logic [2:0] run_len;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_len <= '0;
		end else if (!i_out_valid) begin
			run_len <= '0;
		end else if (run_len != '1) begin
			run_len <= run_len + 1'b1;
		end
	end

	// --------------------------------------------------
	// control checks
	// --------------------------------------------------
	quiet_in_load: assert property (@(posedge clk)
		(!rst_n || i_phase == rnn_pkg::S_LOAD) |-> !i_out_valid)
		else $error("o_out_valid high during reset or load");

	burst_len: assert property (@(posedge clk) disable iff (!rst_n)
		i_out_valid |-> (run_len < 3'(rnn_pkg::DIM)))
		else $error("output burst longer than DIM cycles");

	// done carries the last y word, then idle
	done_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(i_state_q == rnn_pkg::S_DONE) |=>
			((i_state_q == rnn_pkg::S_IDLE) && $past(i_out_valid)))
		else $error("S_DONE without the last output word or no return to S_IDLE");

endmodule

bind rnn_ctrl_fsm rnn_asserts u_asserts (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_state_q   (state),
	.i_phase     (o_state),
	.i_out_valid (o_out_valid)
);

`default_nettype wire

// File: verification/rnn_tb.sv
`default_nettype none

module rnn_tb;

	localparam int FRAC_BITS  = 8;
	localparam int LEAK_SHIFT = 3;
	localparam int NCASES     = 5;
	localparam int DIM        = rnn_pkg::DIM;
	localparam int NWORDS     = rnn_pkg::LOAD_LEN;
	localparam int MAX_WAIT   = 40;
	localparam longint DATA_MAX = 32767;
	localparam longint DATA_MIN = -32768;

	logic           clk = 1'b0;
	logic           rst_n;
	logic           in_valid;
	rnn_pkg::data_t weight_u;
	rnn_pkg::data_t weight_w;
	rnn_pkg::data_t weight_v;
	rnn_pkg::data_t data_x;
	rnn_pkg::data_t data_h;
	logic           out_valid;
	rnn_pkg::data_t out_word;

	// --------------------------------------------------
	// case table, filled before the run
	// --------------------------------------------------
	string          case_name [NCASES];
	int             case_kind [NCASES];
	rnn_pkg::data_t stim_u [NCASES][NWORDS];
	rnn_pkg::data_t stim_w [NCASES][NWORDS];
	rnn_pkg::data_t stim_v [NCASES][NWORDS];
	rnn_pkg::data_t stim_x [NCASES][NWORDS];
	rnn_pkg::data_t stim_h [NCASES][DIM];
	rnn_pkg::data_t exp_y  [NCASES][NWORDS];

	logic [31:0] rng;
	int          n_checks;
	int          n_errors;
	int          n_timeouts;

	always #5 clk = ~clk;

	rnn_top #(
		.FRAC_BITS  (FRAC_BITS),
		.LEAK_SHIFT (LEAK_SHIFT)
	) i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_in_valid  (in_valid),
		.i_weight_u  (weight_u),
		.i_weight_w  (weight_w),
		.i_weight_v  (weight_v),
		.i_data_x    (data_x),
		.i_data_h    (data_h),
		.o_out_valid (out_valid),
		.o_out       (out_word)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// small signed word, roughly -2.0 to +2.0 in Q8
	task automatic next_rand(output rnn_pkg::data_t v);
		int tmp;
		rng = xorshift(rng);
		tmp = int'(rng[9:0]) - 512;
		v = rnn_pkg::data_t'(tmp);
	endtask

	function automatic longint saturate(input longint v);
		if (v > DATA_MAX) begin
			return DATA_MAX;
		end
		if (v < DATA_MIN) begin
			return DATA_MIN;
		end
		return v;
	endfunction

	function automatic longint leaky(input longint v);
		return (v < 0) ? (v >>> LEAK_SHIFT) : v;
	endfunction

	task automatic fill_case(input int c);
		int r;
		int col;
		for (int k = 0; k < NWORDS; k++) begin
			r = k / DIM;
			col = k % DIM;
			case (case_kind[c])
				// identity matrices, 1.0 is 256
				0: begin
					stim_u[c][k] = (r == col) ? 16'sd256 : 16'sd0;
					stim_w[c][k] = (r == col) ? 16'sd256 : 16'sd0;
					stim_v[c][k] = (r == col) ? 16'sd256 : 16'sd0;
					stim_x[c][k] = rnn_pkg::data_t'(32 * (k + 1) - 160);
				end
				// negative weights on positive inputs, V passes h through
				1: begin
					stim_u[c][k] = -16'sd64;
					stim_w[c][k] = -16'sd64;
					stim_v[c][k] = (r == col) ? 16'sd256 : 16'sd0;
					stim_x[c][k] = rnn_pkg::data_t'(256 + 32 * k);
				end
				// full scale, row 1 pulls to the negative limit
				2: begin
					stim_u[c][k] = (r == 1) ? 16'sh8000 : 16'sh7fff;
					stim_w[c][k] = (r == 1) ? 16'sh8000 : 16'sh7fff;
					stim_v[c][k] = (r == 1) ? 16'sh8000 : 16'sh7fff;
					stim_x[c][k] = 16'sh7fff;
				end
				default: begin
					next_rand(stim_u[c][k]);
					next_rand(stim_w[c][k]);
					next_rand(stim_v[c][k]);
					next_rand(stim_x[c][k]);
				end
			endcase
		end
		for (int i = 0; i < DIM; i++) begin
			case (case_kind[c])
				0: stim_h[c][i] = rnn_pkg::data_t'((i == 1) ? -384 : 256 / (i + 1));
				1: stim_h[c][i] = rnn_pkg::data_t'(512 >> i);
				2: stim_h[c][i] = 16'sh7fff;
				default: next_rand(stim_h[c][i]);
			endcase
		end
	endtask

	// h(t+1) = leaky(sat((W.h + U.x) >>> FRAC)), y = sat((V.h(t+1)) >>> FRAC)
	task automatic compute_expected(input int c);
		longint acc;
		longint h [DIM];
		longint hn [DIM];
		for (int i = 0; i < DIM; i++) begin
			h[i] = longint'(stim_h[c][i]);
		end
		for (int t = 0; t < rnn_pkg::STEPS; t++) begin
			for (int r = 0; r < DIM; r++) begin
				acc = 0;
				for (int i = 0; i < DIM; i++) begin
					acc = acc + longint'(stim_w[c][r*DIM+i]) * h[i];
					acc = acc + longint'(stim_u[c][r*DIM+i]) * longint'(stim_x[c][t*DIM+i]);
				end
				hn[r] = leaky(saturate(acc >>> FRAC_BITS));
			end
			h = hn;
			for (int r = 0; r < DIM; r++) begin
				acc = 0;
				for (int i = 0; i < DIM; i++) begin
					acc = acc + longint'(stim_v[c][r*DIM+i]) * h[i];
				end
				exp_y[c][t*DIM+r] = rnn_pkg::data_t'(saturate(acc >>> FRAC_BITS));
			end
		end
	endtask

	task automatic check_idle(input string name, input bit check_zero);
		n_checks++;
		if (out_valid !== 1'b0) begin
			n_errors++;
			$display("Mismatch %s o_out_valid: expected 0, actual %b", name, out_valid);
		end
		if (check_zero && out_word !== 16'sd0) begin
			n_errors++;
			$display("Mismatch %s o_out: expected 0, actual %0d", name, out_word);
		end
	endtask

	// --------------------------------------------------
	// stream one case in, then gather its nine words
	// --------------------------------------------------
	task automatic load_case(input int c, input bit check_zero);
		for (int k = 0; k < NWORDS; k++) begin
			@(posedge clk);
			#1;
			in_valid = 1'b1;
			weight_u = stim_u[c][k];
			weight_w = stim_w[c][k];
			weight_v = stim_v[c][k];
			data_x   = stim_x[c][k];
			if (k < DIM) begin
				data_h = stim_h[c][k];
			end else begin
				// ignored by the DUT after the first row
				data_h = 16'sh5a5a;
			end
			@(negedge clk);
			check_idle(case_name[c], check_zero);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		weight_u = '0;
		weight_w = '0;
		weight_v = '0;
		data_x   = '0;
		data_h   = '0;
	endtask

	task automatic collect_case(input int c);
		int cyc;
		int n_out;
		int want_cyc;
		cyc = 0;
		n_out = 0;
		while (n_out < NWORDS && cyc < MAX_WAIT) begin
			@(negedge clk);
			cyc++;
			if (out_valid === 1'b1) begin
				// first word 5 cycles after the last load word, bursts 2*DIM apart
				want_cyc = 5 + 2 * DIM * (n_out / DIM) + (n_out % DIM);
				n_checks += 2;
				if (cyc != want_cyc) begin
					n_errors++;
					$display("Mismatch %s y[%0d] cycle: expected %0d, actual %0d",
						case_name[c], n_out, want_cyc, cyc);
				end
				if (out_word !== exp_y[c][n_out]) begin
					n_errors++;
					$display("Mismatch %s y[%0d]: expected %0d, actual %0d",
						case_name[c], n_out, exp_y[c][n_out], out_word);
				end
				n_out++;
			end
		end
		if (n_out < NWORDS) begin
			n_timeouts++;
			$display("Timeout: case %s gave only %0d of %0d outputs within %0d cycles",
				case_name[c], n_out, NWORDS, MAX_WAIT);
		end
	endtask

	initial begin
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		weight_u   = '0;
		weight_w   = '0;
		weight_v   = '0;
		data_x     = '0;
		data_h     = '0;
		n_checks   = 0;
		n_errors   = 0;
		n_timeouts = 0;
		rng        = 32'd41384;

		case_name[0] = "identity";
		case_kind[0] = 0;
		case_name[1] = "negative_preact";
		case_kind[1] = 1;
		case_name[2] = "saturate";
		case_kind[2] = 2;
		case_name[3] = "random_a";
		case_kind[3] = 3;
		case_name[4] = "random_b";
		case_kind[4] = 3;
		for (int c = 0; c < NCASES; c++) begin
			fill_case(c);
			compute_expected(c);
		end

		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			check_idle("reset", 1'b1);
		end

		// cases run back to back, the next load starts right after S_DONE
		for (int c = 0; c < NCASES; c++) begin
			load_case(c, c == 0);
			collect_case(c);
		end

		$display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
hdl/rnn_pkg.sv
hdl/rnn_dot_unit.sv
hdl/rnn_step_counter.sv
hdl/rnn_operand_store.sv
hdl/rnn_hidden_store.sv
hdl/rnn_ctrl_fsm.sv
hdl/rnn_top.sv
verification/rnn_asserts.sv
verification/rnn_tb.sv

// File: Makefile
SIM := obj_dir/rnn_sim
SRCS := $(wildcard hdl/*.sv) $(wildcard verification/*.sv)

.PHONY: all run lint clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -f list.f --top-module rnn_tb -o rnn_sim

# pass only when the testbench printed its pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module rnn_tb

clean:
	rm -rf obj_dir
